// ==== src/core_pkg.sv ====
// core_pkg: shared widths, opcodes, ALU operations and the decoded bundle of the core
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // multiplier occupancy and its step counter
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] FUNCT7_MUL = 7'b0000001;
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  imm_sel;
        logic [XLEN-1:0]       imm;
        logic                  long_inst;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } dec_info_t;

endpackage

`default_nettype wire

// ==== src/wb_if.sv ====
// wb_if: one result travelling from an execute unit to writeback with ready/valid
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    logic                           valid;
    logic [core_pkg::REG_ADDR_W-1:0] addr;
    logic [core_pkg::XLEN-1:0]       data;
    logic                           ready;

    // execute side holds valid, addr and data until ready
    modport source (
        output valid, addr, data,
        input  ready
    );

    modport sink (
        input  valid, addr, data,
        output ready
    );

endinterface

`default_nettype wire

// ==== src/ifu.sv ====
// ifu: program counter and fetched-instruction register
`timescale 1ns/1ps
`default_nettype none

module ifu (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic [core_pkg::XLEN-1:0] inst_i,
    output logic [core_pkg::XLEN-1:0] pc_o,
    output logic [core_pkg::XLEN-1:0] inst_o
);

    logic [core_pkg::XLEN-1:0] pc_q;
    logic [core_pkg::XLEN-1:0] inst_q;

    // straight-line fetch, both registers freeze on a stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q   <= '0;
            inst_q <= core_pkg::NOP_INST;
        end else if (!stall_i) begin
            pc_q   <= pc_q + core_pkg::XLEN'(4);
            inst_q <= inst_i;
        end
    end

    assign pc_o   = pc_q;
    assign inst_o = inst_q;

endmodule

`default_nettype wire

// ==== src/idu.sv ====
// idu: instruction decoder and the decode-to-execute pipeline register
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic [core_pkg::XLEN-1:0] inst_i,
    output logic                      issue_o,
    output core_pkg::dec_info_t       dec_o,
    output core_pkg::dec_info_t       pre_dec_o
);

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [6:0]                      funct7;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic                            known;
    core_pkg::dec_info_t             dec;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    always_comb begin
        dec        = '0;
        dec.alu_op = core_pkg::ALU_ADD;
        dec.rd     = rd;
        known      = 1'b0;
        case (opcode)
            core_pkg::OPC_OP: begin
                dec.rs1 = inst_i[19:15];
                dec.rs2 = inst_i[24:20];
                known   = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}:          dec.alu_op = core_pkg::ALU_ADD;
                    {core_pkg::FUNCT7_SUB, 3'b000}: dec.alu_op = core_pkg::ALU_SUB;
                    {7'b0000000, 3'b100}:          dec.alu_op = core_pkg::ALU_XOR;
                    {7'b0000000, 3'b110}:          dec.alu_op = core_pkg::ALU_OR;
                    {7'b0000000, 3'b111}:          dec.alu_op = core_pkg::ALU_AND;
                    {core_pkg::FUNCT7_MUL, 3'b000}: dec.long_inst = 1'b1;
                    default:                       known = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                // only addi is supported
                dec.rs1     = inst_i[19:15];
                dec.imm     = {{20{inst_i[31]}}, inst_i[31:20]};
                dec.imm_sel = 1'b1;
                known       = (funct3 == 3'b000);
            end
            core_pkg::OPC_LUI: begin
                dec.imm     = {inst_i[31:12], 12'b0};
                dec.imm_sel = 1'b1;
                dec.alu_op  = core_pkg::ALU_PASS;
                known       = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // writes to x0 and unknown opcodes collapse to a plain no-op
        dec.we = known && (rd != '0);
        if (!dec.we) begin
            dec.long_inst = 1'b0;
            dec.rs1       = '0;
            dec.rs2       = '0;
        end
    end

    assign pre_dec_o = dec;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o <= 1'b0;
            dec_o   <= '0;
        end else begin
            // a stalled slot issues nothing, the payload holds
            issue_o <= !stall_i;
            if (!stall_i) begin
                dec_o <= dec;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/hdu.sv ====
// hdu: per-register busy scoreboard, multiplier occupancy and the issue stall
`timescale 1ns/1ps
`default_nettype none

module hdu (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  core_pkg::dec_info_t             dec_i,
    input  logic                            issue_i,
    input  logic                            commit_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] commit_addr_i,
    input  logic                            alu_stall_i,
    output logic                            stall_o
);

    logic [core_pkg::NUM_REGS-1:0]   busy_q;
    logic [core_pkg::NUM_REGS-1:0]   busy_v;
    logic [core_pkg::NUM_REGS-1:0]   set_vec;
    logic [core_pkg::NUM_REGS-1:0]   clr_vec;
    logic                            mul_busy_q;
    logic                            mul_busy_v;
    logic [core_pkg::REG_ADDR_W-1:0] mul_rd_q;
    // copy of the instruction sitting in the issue register
    logic                            we_q;
    logic                            long_q;
    logic [core_pkg::REG_ADDR_W-1:0] rd_q;

    assign set_vec = (issue_i && we_q) ? (core_pkg::NUM_REGS'(1) << rd_q) : '0;
    assign clr_vec = commit_i ? (core_pkg::NUM_REGS'(1) << commit_addr_i) : '0;

    // the instruction issuing this cycle already counts as busy
    assign busy_v     = busy_q | set_vec;
    assign mul_busy_v = mul_busy_q | (issue_i && long_q);

    assign stall_o = busy_v[dec_i.rs1] | busy_v[dec_i.rs2]
                   | (dec_i.we && busy_v[dec_i.rd])
                   | (dec_i.long_inst && mul_busy_v)
                   | alu_stall_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q     <= '0;
            mul_busy_q <= 1'b0;
            we_q       <= 1'b0;
            long_q     <= 1'b0;
        end else begin
            busy_q <= (busy_q & ~clr_vec) | set_vec;
            if (issue_i && long_q) begin
                mul_busy_q <= 1'b1;
            end else if (commit_i && (commit_addr_i == mul_rd_q)) begin
                // only the multiplier can write its rd while it runs
                mul_busy_q <= 1'b0;
            end
            if (!stall_o) begin
                we_q   <= dec_i.we;
                long_q <= dec_i.long_inst;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            rd_q <= dec_i.rd;
        end
        if (issue_i && long_q) begin
            mul_rd_q <= rd_q;
        end
    end

endmodule

`default_nettype wire

// ==== src/regs.sv ====
// regs: 32-entry integer register file with write-through reads
`timescale 1ns/1ps
`default_nettype none

module regs (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);

    logic [core_pkg::XLEN-1:0] rf_q [core_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            rf_q[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired, a write in the same cycle is forwarded
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr1_i)) ? wdata_i : rf_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr2_i)) ? wdata_i : rf_q[raddr2_i];

endmodule

`default_nettype wire

// ==== src/exu.sv ====
// exu: single-cycle ALU with a result register held until writeback accepts it
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      issue_i,
    input  core_pkg::dec_info_t       dec_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    wb_if.source                      wb,
    output logic                      stall_o
);

    logic [core_pkg::XLEN-1:0]       opb;
    logic [core_pkg::XLEN-1:0]       alu_res;
    logic                            alu_req;
    logic                            slot_free;
    logic                            valid_q;
    // issued while the result register was still waiting
    logic                            pend_q;
    logic [core_pkg::XLEN-1:0]       res_q;
    logic [core_pkg::REG_ADDR_W-1:0] rd_q;

    assign opb = dec_i.imm_sel ? dec_i.imm : rs2_data_i;

    always_comb begin
        case (dec_i.alu_op)
            core_pkg::ALU_ADD:  alu_res = rs1_data_i + opb;
            core_pkg::ALU_SUB:  alu_res = rs1_data_i - opb;
            core_pkg::ALU_AND:  alu_res = rs1_data_i & opb;
            core_pkg::ALU_OR:   alu_res = rs1_data_i | opb;
            core_pkg::ALU_XOR:  alu_res = rs1_data_i ^ opb;
            core_pkg::ALU_PASS: alu_res = dec_i.imm;
            default:            alu_res = '0;
        endcase
    end

    assign alu_req   = (issue_i || pend_q) && dec_i.we && !dec_i.long_inst;
    assign slot_free = !valid_q || wb.ready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            pend_q  <= 1'b0;
        end else if (alu_req && slot_free) begin
            valid_q <= 1'b1;
            pend_q  <= 1'b0;
        end else begin
            if (wb.ready) begin
                valid_q <= 1'b0;
            end
            if (alu_req) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_req && slot_free) begin
            res_q <= alu_res;
            rd_q  <= dec_i.rd;
        end
    end

    assign wb.valid = valid_q;
    assign wb.addr  = rd_q;
    assign wb.data  = res_q;
    assign stall_o  = valid_q && !wb.ready;

endmodule

`default_nettype wire

// ==== src/muldiv.sv ====
// muldiv: iterative shift-add multiplier returning the low word of the product
`timescale 1ns/1ps
`default_nettype none

module muldiv (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      issue_i,
    input  core_pkg::dec_info_t       dec_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    wb_if.source                      wb
);

    logic                            start;
    logic                            run_q;
    logic                            valid_q;
    logic [core_pkg::MUL_CNT_W-1:0]  cnt_q;
    logic [core_pkg::XLEN-1:0]       acc_q;
    logic [core_pkg::XLEN-1:0]       mcand_q;
    logic [core_pkg::XLEN-1:0]       mplier_q;
    logic [core_pkg::XLEN-1:0]       addend;
    logic [core_pkg::REG_ADDR_W-1:0] rd_q;

    assign start  = issue_i && dec_i.long_inst && !run_q && !valid_q;
    assign addend = mplier_q[0] ? mcand_q : '0;

    // first step is folded into the load, the last one raises valid
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (start) begin
            run_q <= 1'b1;
            cnt_q <= core_pkg::MUL_CNT_W'(1);
        end else if (run_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == core_pkg::MUL_CNT_W'(core_pkg::MUL_CYCLES - 1)) begin
                run_q   <= 1'b0;
                valid_q <= 1'b1;
            end
        end else if (valid_q && wb.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_q    <= rs2_data_i[0] ? rs1_data_i : '0;
            mcand_q  <= rs1_data_i << 1;
            mplier_q <= rs2_data_i >> 1;
            rd_q     <= dec_i.rd;
        end else if (run_q) begin
            acc_q    <= acc_q + addend;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign wb.valid = valid_q;
    assign wb.addr  = rd_q;
    assign wb.data  = acc_q;

endmodule

`default_nettype wire

// ==== src/wbu.sv ====
// wbu: writeback arbiter giving the multiplier priority over the ALU
`timescale 1ns/1ps
`default_nettype none

module wbu (
    wb_if.sink                              alu,
    wb_if.sink                              mul,
    output logic                            we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic [core_pkg::XLEN-1:0]       wdata_o
);

    logic mul_grant;
    logic alu_grant;

    // fixed priority, one register write per cycle
    assign mul_grant = mul.valid;
    assign alu_grant = alu.valid && !mul.valid;

    assign mul.ready = 1'b1;
    assign alu.ready = !mul.valid;

    always_comb begin
        we_o    = 1'b0;
        waddr_o = '0;
        wdata_o = '0;
        if (mul_grant) begin
            we_o    = 1'b1;
            waddr_o = mul.addr;
            wdata_o = mul.data;
        end else if (alu_grant) begin
            we_o    = 1'b1;
            waddr_o = alu.addr;
            wdata_o = alu.data;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
// cpu_top: in-order RV32 integer core with out-of-order multiply writeback
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    output logic [core_pkg::XLEN-1:0]       pc_o,
    input  logic [core_pkg::XLEN-1:0]       inst_i,
    output logic                            wb_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o
);

    logic [core_pkg::XLEN-1:0] ifu_inst;
    logic                      idu_issue;
    core_pkg::dec_info_t       idu_dec;
    core_pkg::dec_info_t       idu_pre_dec;
    logic                      hdu_stall;
    logic                      exu_stall;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;

    wb_if alu_wb ();
    wb_if mul_wb ();

    ifu u_ifu (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .stall_i(hdu_stall),
        .inst_i (inst_i),
        .pc_o   (pc_o),
        .inst_o (ifu_inst)
    );

    idu u_idu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (hdu_stall),
        .inst_i   (ifu_inst),
        .issue_o  (idu_issue),
        .dec_o    (idu_dec),
        .pre_dec_o(idu_pre_dec)
    );

    hdu u_hdu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dec_i        (idu_pre_dec),
        .issue_i      (idu_issue),
        .commit_i     (wb_valid_o),
        .commit_addr_i(wb_addr_o),
        .alu_stall_i  (exu_stall),
        .stall_o      (hdu_stall)
    );

    // operands are read in the execute cycle
    regs u_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_valid_o),
        .waddr_i (wb_addr_o),
        .wdata_i (wb_data_o),
        .raddr1_i(idu_dec.rs1),
        .raddr2_i(idu_dec.rs2),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    exu u_exu (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .issue_i   (idu_issue),
        .dec_i     (idu_dec),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .wb        (alu_wb),
        .stall_o   (exu_stall)
    );

    muldiv u_muldiv (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .issue_i   (idu_issue),
        .dec_i     (idu_dec),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .wb        (mul_wb)
    );

    // the register write doubles as the commit port
    wbu u_wbu (
        .alu    (alu_wb),
        .mul    (mul_wb),
        .we_o   (wb_valid_o),
        .waddr_o(wb_addr_o),
        .wdata_o(wb_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/cpu_top_chk.sv ====
// cpu_top_chk: concurrent checks on the commit port and program counter of the core
`timescale 1ns/1ps
`default_nettype none

module cpu_top_chk (
    input logic                            clk,
    input logic                            rst_n_i,
    input logic [core_pkg::XLEN-1:0]       pc_o,
    input logic                            wb_valid_o,
    input logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o
);

    // the decoder turns x0 writes into no-ops
    no_x0_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> (wb_addr_o != '0))
        else $error("commit to x0");

    // straight-line fetch only
    pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        1'b1 |=> (pc_o == $past(pc_o)) || (pc_o == $past(pc_o) + 32'd4))
        else $error("pc_o neither held nor advanced by 4");

    quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !wb_valid_o)
        else $error("commit while reset is asserted");

endmodule

bind cpu_top cpu_top_chk u_chk (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .pc_o      (pc_o),
    .wb_valid_o(wb_valid_o),
    .wb_addr_o (wb_addr_o)
);

`default_nettype wire

// ==== dv/tb_cpu_top.sv ====
// tb_cpu_top: testbench running a random straight-line program against a sequential model
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int PROG_MAX = 128;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] pc_o;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] prog [PROG_MAX];
    logic [31:0] exp_val [PROG_MAX];
    string       test_name [PROG_MAX];
    // program indices of the writes still owed to each register
    int          pend_q [32][$];
    logic [31:0] model_rf [32];
    logic [31:0] last_val [32];
    int          prog_len;
    int          pending;
    int          checks;
    int          errors;
    int          seed;
    string       cur_test;

    cpu_top u_dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pc_o      (pc_o),
        .inst_i    (inst_i),
        .wb_valid_o(wb_valid_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    always #50 clk = ~clk;

    // instruction memory, no-ops past the program
    assign inst_i = (pc_o[31:2] < 30'(PROG_MAX)) ? prog[pc_o[8:2]] : core_pkg::NOP_INST;

    task automatic append_inst(input logic [31:0] inst, input logic [4:0] rd,
                               input logic [31:0] val);
        prog[prog_len]      = inst;
        exp_val[prog_len]   = val;
        test_name[prog_len] = cur_test;
        // x0 stays zero and never commits
        if (rd != 5'd0) begin
            model_rf[rd] = val;
            pend_q[rd].push_back(prog_len);
            pending++;
        end
        prog_len++;
    endtask

    task automatic reg_reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model_rf[rs1];
        b = model_rf[rs2];
        case ({f7, f3})
            {7'h00, 3'h0}: res = a + b;
            {7'h20, 3'h0}: res = a - b;
            {7'h00, 3'h7}: res = a & b;
            {7'h00, 3'h6}: res = a | b;
            {7'h00, 3'h4}: res = a ^ b;
            // mul keeps the low word
            default:       res = a * b;
        endcase
        append_inst({f7, rs2, rs1, f3, rd, core_pkg::OPC_OP}, rd, res);
    endtask

    task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        append_inst({imm, rs1, 3'b000, rd, core_pkg::OPC_OP_IMM}, rd,
                    model_rf[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        append_inst({imm, rd, core_pkg::OPC_LUI}, rd, {imm, 12'h000});
    endtask

    task automatic random_op(input logic [4:0] rd);
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         kind;
        rs1  = 5'($unsigned($random(seed)));
        rs2  = 5'($unsigned($random(seed)));
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0: reg_reg_op(7'h00, 3'h0, rd, rs1, rs2);
            1: reg_reg_op(7'h20, 3'h0, rd, rs1, rs2);
            2: reg_reg_op(7'h00, 3'h7, rd, rs1, rs2);
            3: reg_reg_op(7'h00, 3'h6, rd, rs1, rs2);
            4: reg_reg_op(7'h00, 3'h4, rd, rs1, rs2);
            5: reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, rd, rs1, rs2);
            6: add_imm(rd, rs1, 12'($random(seed)));
            default: load_upper(rd, 20'($random(seed)));
        endcase
    endtask

    task automatic build_program();
        cur_test = "load";
        for (int r = 1; r <= 8; r++) begin
            load_upper(5'(r), 20'($random(seed)));
            add_imm(5'(r), 5'(r), 12'($random(seed)));
        end
        cur_test = "alu_rr";
        reg_reg_op(7'h00, 3'h0, 5'd9, 5'd1, 5'd2);
        reg_reg_op(7'h20, 3'h0, 5'd10, 5'd3, 5'd4);
        reg_reg_op(7'h00, 3'h7, 5'd11, 5'd5, 5'd6);
        reg_reg_op(7'h00, 3'h6, 5'd12, 5'd7, 5'd8);
        reg_reg_op(7'h00, 3'h4, 5'd13, 5'd1, 5'd8);
        // writes to x0 are dropped
        reg_reg_op(7'h00, 3'h0, 5'd0, 5'd1, 5'd2);
        cur_test = "immediate";
        add_imm(5'd14, 5'd2, 12'h800);
        add_imm(5'd15, 5'd0, 12'h7ff);
        load_upper(5'd16, 20'hfffff);
        cur_test = "mul";
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd17, 5'd1, 5'd2);
        // second multiply waits for the multiplier
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd18, 5'd3, 5'd4);
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd0, 5'd5, 5'd6);
        cur_test = "dependency";
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd19, 5'd5, 5'd6);
        reg_reg_op(7'h00, 3'h4, 5'd20, 5'd7, 5'd8);
        add_imm(5'd21, 5'd9, 12'h001);
        reg_reg_op(7'h00, 3'h0, 5'd22, 5'd19, 5'd1);
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd23, 5'd19, 5'd22);
        cur_test = "backpressure";
        // alu results stream past the multiplier and collide with its commit
        reg_reg_op(core_pkg::FUNCT7_MUL, 3'h0, 5'd24, 5'd1, 5'd2);
        for (int i = 0; i < 40; i++) begin
            add_imm(5'(25 + i % 4), 5'd3, 12'(i));
        end
        cur_test = "random";
        for (int i = 0; i < 40; i++) begin
            random_op(5'(1 + $unsigned($random(seed)) % 31));
        end
    endtask

    // commits are stable by the falling edge
    always @(negedge clk) begin : commit_check
        int idx;
        if (!rst_n_i) begin
            checks++;
            assert (pc_o == '0 && !wb_valid_o) else begin
                $display("Mismatch reset: expected pc 00000000 no commit, actual pc %08h commit %0b",
                         pc_o, wb_valid_o);
                errors++;
            end
        end else if (wb_valid_o) begin
            checks++;
            assert (pend_q[wb_addr_o].size() > 0) else begin
                $display("commit to x%0d without any pending write", wb_addr_o);
                errors++;
            end
            if (pend_q[wb_addr_o].size() > 0) begin
                idx = pend_q[wb_addr_o].pop_front();
                pending--;
                assert (wb_data_o === exp_val[idx]) else begin
                    $display("Mismatch %s: x%0d expected %08h actual %08h",
                             test_name[idx], wb_addr_o, exp_val[idx], wb_data_o);
                    errors++;
                end
            end
            last_val[wb_addr_o] = wb_data_o;
        end
    end

    initial begin : run_program
        seed     = 70099;
        clk      = 1'b0;
        rst_n_i  = 1'b0;
        prog_len = 0;
        pending  = 0;
        checks   = 0;
        errors   = 0;
        for (int i = 0; i < PROG_MAX; i++) begin
            prog[i] = core_pkg::NOP_INST;
        end
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
            last_val[r] = '0;
        end
        build_program();
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        wait (pending == 0);
        // idle cycles to catch stray commits
        repeat (10) @(posedge clk);
        for (int r = 1; r < 32; r++) begin
            checks++;
            assert (last_val[r] === model_rf[r]) else begin
                $display("Mismatch final_state: x%0d expected %08h actual %08h",
                         r, model_rf[r], last_val[r]);
                errors++;
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = prog_len * (core_pkg::MUL_CYCLES + 4) + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles with %0d commits outstanding", limit, pending);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/core_pkg.sv
src/wb_if.sv
src/ifu.sv
src/idu.sv
src/hdu.sv
src/regs.sv
src/exu.sv
src/muldiv.sv
src/wbu.sv
src/cpu_top.sv
dv/cpu_top_chk.sv
dv/tb_cpu_top.sv

// ==== Makefile ====
# Verilator build and run of the core testbench, all variables can be overridden
VERILATOR  ?= verilator
TOP        ?= tb_cpu_top
RTL_TOP    ?= cpu_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
